// File: bench/clock_gen.sv
/* Free-running testbench clock, starts low at time 0. */
`timescale 1ns/1ns

module clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic o_clk
);

  initial
  begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

endmodule

// File: bench/debugger_tb.sv
/* Testbench for the SPI memory debugger. Random bursts from a fixed seed are checked
   against a sparse memory model; reads only target addresses already written. */
`timescale 1ns/1ns

module debugger_tb;

  localparam int HALF_SCK        = 4;                    // i_clk cycles per SCK phase
  localparam int BYTE_CYCLES     = 16 * HALF_SCK;
  localparam int DATA_START      = debug_pkg::HDR_BYTES + 1;
  localparam int MAX_FRAMES      = 60;
  localparam int MAX_FRAME_BYTES = 22;
  localparam int FRAME_OVERHEAD  = 16;                   // CS setup, hold and gap
  // worst case run length plus a fifth for margin
  localparam int TIMEOUT_CYCLES =
    MAX_FRAMES * (MAX_FRAME_BYTES * BYTE_CYCLES + FRAME_OVERHEAD) * 6 / 5;

  logic clk;
  logic arst_n;
  logic spi_clk;
  logic spi_cs_n;
  logic spi_copi;
  logic spi_cipo;

  int seed      = 80912;
  int cycle_cnt = 0;

  debug_pkg::byte_t model [debug_pkg::addr_t];           // every byte written so far
  debug_pkg::byte_t tx_q [$];
  debug_pkg::byte_t rx_q [$];
  debug_pkg::byte_t exp_q [$];
  debug_pkg::addr_t burst_addr [$];                      // written bursts that reads may target
  int               burst_len [$];

  clock_gen #(.PERIOD_NS(40)) clk_gen (.o_clk(clk));

  debugger_top uut (
    .i_clk      (clk),
    .i_arst_n   (arst_n),
    .i_spi_clk  (spi_clk),
    .i_spi_cs_n (spi_cs_n),
    .i_spi_copi (spi_copi),
    .o_spi_cipo (spi_cipo)
  );

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_byte(input string name, input debug_pkg::byte_t exp,
                            input debug_pkg::byte_t act);
    if (act !== exp)
    begin
      $display("[ERROR] time %0t %s expected 0x%02h actual 0x%02h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles)
    begin
      @(negedge clk);
      if (spi_cipo !== 1'b0)
      begin
        $display("[ERROR] time %0t o_spi_cipo expected 0 actual %b", $time, spi_cipo);
        abort_run();
      end
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // mode 0, MSB first, CIPO sampled together with each SCK rise
  task automatic shift_byte(input debug_pkg::byte_t data, input int nbits,
                            output debug_pkg::byte_t rx);
    rx = '0;
    for (int b = 0; b < nbits; b++)
    begin
      spi_copi = data[debug_pkg::DATA_W-1-b];
      wait_cycles(HALF_SCK);
      spi_clk = 1'b1;
      rx      = {rx[debug_pkg::DATA_W-2:0], spi_cipo};
      wait_cycles(HALF_SCK);
      spi_clk = 1'b0;
    end
  endtask

  // sends tx_q as one frame and then part_bits of a cut-off byte
  task automatic run_frame(input int part_bits);
    debug_pkg::byte_t rx;
    rx_q.delete();
    spi_cs_n = 1'b0;
    foreach (tx_q[i])
    begin
      shift_byte(tx_q[i], debug_pkg::DATA_W, rx);
      rx_q.push_back(rx);
    end
    if (part_bits > 0)
      shift_byte(debug_pkg::byte_t'(rand_below(256)), part_bits, rx);
    wait_cycles(HALF_SCK);
    spi_cs_n = 1'b1;
    spi_copi = 1'b0;
    wait_cycles(3);                                      // CS sync latency
    check_idle(4);
  endtask

  task automatic check_reply(input string what);
    foreach (exp_q[i])
      check_byte($sformatf("o_spi_cipo (%s byte %0d)", what, i), exp_q[i], rx_q[i]);
  endtask

  // command byte and the 4 header bytes that are all answered with 0x00
  task automatic push_header(input debug_pkg::byte_t cmd, input debug_pkg::addr_t addr,
                             input int len);
    debug_pkg::addr_t len_w;
    len_w = debug_pkg::addr_t'(len);
    tx_q.delete();
    exp_q.delete();
    tx_q.push_back(cmd);
    tx_q.push_back(debug_pkg::byte_t'(addr >> debug_pkg::DATA_W));
    tx_q.push_back(debug_pkg::byte_t'(addr));
    tx_q.push_back(debug_pkg::byte_t'(len_w >> debug_pkg::DATA_W));
    tx_q.push_back(debug_pkg::byte_t'(len_w));
    repeat (DATA_START) exp_q.push_back(8'h00);
  endtask

  task automatic write_burst(input debug_pkg::addr_t addr, input int len, input int sent,
                             input int part_bits);
    int stored;
    push_header(debug_pkg::CMD_WRITE, addr, len);
    for (int k = 0; k < sent; k++)
    begin
      tx_q.push_back(debug_pkg::byte_t'(rand_below(256)));
      exp_q.push_back(8'h00);
    end
    run_frame(part_bits);
    check_reply("write");
    stored = (sent < len) ? sent : len;                  // only completed data bytes
    for (int k = 0; k < stored; k++)
      model[debug_pkg::addr_t'(addr + k)] = tx_q[DATA_START + k];
    if (stored > 0)
    begin
      burst_addr.push_back(addr);
      burst_len.push_back(stored);
    end
  endtask

  task automatic read_burst(input debug_pkg::addr_t addr, input int len, input int extra);
    push_header(debug_pkg::CMD_READ, addr, len);
    for (int k = 0; k < len + extra; k++)
    begin
      tx_q.push_back(debug_pkg::byte_t'(rand_below(256)));   // dummy bytes
      exp_q.push_back((k < len) ? model[debug_pkg::addr_t'(addr + k)] : 8'h00);
    end
    run_frame(0);
    check_reply("read");
  endtask

  // part or all of an earlier burst, so every address read holds known data
  task automatic read_random_burst();
    int idx;
    int off;
    int len;
    idx = rand_below(burst_addr.size());
    off = rand_below(burst_len[idx]);
    len = rand_below(burst_len[idx] - off + 1);
    read_burst(debug_pkg::addr_t'(burst_addr[idx] + off), len, (len < 16) ? 1 : 0);
  endtask

  task automatic cut_write();
    int               idx;
    int               len;
    debug_pkg::addr_t addr;
    do
      idx = rand_below(burst_addr.size());
    while (burst_len[idx] < 2);
    addr = burst_addr[idx];
    len  = burst_len[idx];
    write_burst(addr, len, rand_below(len), 1 + rand_below(debug_pkg::DATA_W - 1));
    read_burst(addr, len, 0);
  endtask

  // a write-shaped frame behind an unknown command must leave memory alone
  task automatic unknown_frame();
    int               idx;
    debug_pkg::byte_t cmd;
    idx = rand_below(burst_addr.size());
    do
      cmd = debug_pkg::byte_t'(rand_below(256));
    while (cmd == debug_pkg::CMD_READ || cmd == debug_pkg::CMD_WRITE ||
           cmd == debug_pkg::CMD_ID);
    push_header(cmd, burst_addr[idx], burst_len[idx]);
    for (int k = 0; k < burst_len[idx]; k++)
    begin
      tx_q.push_back(debug_pkg::byte_t'(rand_below(256)));
      exp_q.push_back(8'h00);
    end
    run_frame(0);
    check_reply("unknown command");
    read_burst(burst_addr[idx], burst_len[idx], 0);
  endtask

  task automatic id_frame(input int nbytes);
    tx_q.delete();
    exp_q.delete();
    tx_q.push_back(debug_pkg::CMD_ID);
    exp_q.push_back(8'h00);
    for (int k = 1; k < nbytes; k++)
    begin
      tx_q.push_back(debug_pkg::byte_t'(rand_below(256)));
      exp_q.push_back((k == 1) ? debug_pkg::ID_VALUE : 8'h00);
    end
    run_frame(0);
    check_reply("identity");
  endtask

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES)
    begin
      $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  initial
  begin
    arst_n   = 1'b0;
    spi_clk  = 1'b0;
    spi_cs_n = 1'b1;
    spi_copi = 1'b0;
    @(posedge clk);
    check_idle(4);                                       // 4 cycles in reset
    arst_n = 1'b1;
    check_idle(8);
    id_frame(3);
    write_burst(debug_pkg::addr_t'(rand_below(65536)), 16, 16, 0);
    repeat (20)
    begin
      int len;
      len = rand_below(17);
      write_burst(debug_pkg::addr_t'(rand_below(65536)), len, len, 0);
      read_random_burst();
    end
    repeat (4) cut_write();
    repeat (3) unknown_frame();
    write_burst(16'hFFF8, 16, 16, 0);                   // runs over the top of memory
    read_burst(16'hFFFC, 8, 1);
    read_burst(16'hFFF8, 16, 0);
    id_frame(4);
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: common/debug_pkg.sv
/* Shared widths, command codes and types for the SPI memory debugger.
   Byte width and address width are fixed by the command format (2 address bytes). */

package debug_pkg;

  localparam int DATA_W = 8;                     // one SPI byte
  localparam int ADDR_W = 16;                    // 64 KiB byte memory

  localparam int BIT_CNT_W = $clog2(DATA_W);     // bit index within a byte

  // header after READ/WRITE is addr hi, addr lo, len hi, len lo
  localparam int HDR_BYTES = 4;
  localparam int HDR_IDX_W = $clog2(HDR_BYTES);

  typedef logic [DATA_W-1:0] byte_t;
  typedef logic [ADDR_W-1:0] addr_t;             // also used for burst lengths

  // command byte, first byte of every frame
  typedef enum byte_t {
    CMD_READ  = 8'h01,
    CMD_WRITE = 8'h02,
    CMD_ID    = 8'h03
  } cmd_e;

  localparam byte_t ID_VALUE = 8'h65;            // reply to CMD_ID

  // controller FSM states
  typedef enum logic [2:0] {
    CMD,                                         // waiting for command byte
    HDR,                                         // collecting header bytes
    RD_DATA,                                     // read burst, one read per dummy byte
    WR_DATA,                                     // write burst, one write per data byte
    DONE                                         // ignore bytes until CS rises
  } ctrl_state_e;

endpackage

// File: debugger/debug_controller.sv
/* Command FSM of the debugger. One command per CS frame; CS rising drops any burst.
   Malformed or unknown commands get no error reply, only 0x00 filler. */
`timescale 1ns/1ns

module debug_controller (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  logic             i_rx_dv,
  input  debug_pkg::byte_t i_rx_byte,
  input  logic             i_frame_active,
  input  debug_pkg::byte_t i_mem_rdata,
  output logic             o_tx_dv,
  output debug_pkg::byte_t o_tx_byte,
  output logic             o_mem_en,
  output logic             o_mem_we,
  output debug_pkg::addr_t o_mem_addr,
  output debug_pkg::byte_t o_mem_wdata
);

  debug_pkg::ctrl_state_e          state;
  debug_pkg::cmd_e                 cmd_q;
  logic [debug_pkg::HDR_IDX_W-1:0] hdr_idx;
  debug_pkg::addr_t                addr_q;       // address of the next access
  debug_pkg::addr_t                count_q;      // accesses still to issue
  debug_pkg::addr_t                hdr_len;
  logic                            id_pending;
  logic                            rd_pending;   // read data valid this cycle

  // length high byte sits in count_q until the last header byte arrives
  assign hdr_len = {count_q[debug_pkg::ADDR_W-1:debug_pkg::DATA_W], i_rx_byte};

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      state      <= debug_pkg::CMD;
      cmd_q      <= debug_pkg::CMD_ID;
      hdr_idx    <= '0;
      addr_q     <= '0;
      count_q    <= '0;
      o_mem_en   <= 1'b0;
      o_mem_we   <= 1'b0;
      id_pending <= 1'b0;
      rd_pending <= 1'b0;
    end
    else
    begin
      o_mem_en   <= 1'b0;
      o_mem_we   <= 1'b0;
      id_pending <= 1'b0;
      rd_pending <= o_mem_en & ~o_mem_we;        // RAM data lands next cycle
      if (o_mem_en)
        addr_q <= addr_q + 1'b1;                 // wraps modulo 2^16
      if (!i_frame_active)
      begin
        state      <= debug_pkg::CMD;
        hdr_idx    <= '0;
        rd_pending <= 1'b0;
      end
      else if (i_rx_dv)
      begin
        case (state)
          debug_pkg::CMD:
          begin
            cmd_q   <= debug_pkg::cmd_e'(i_rx_byte);
            hdr_idx <= '0;
            case (debug_pkg::cmd_e'(i_rx_byte))
              debug_pkg::CMD_READ,
              debug_pkg::CMD_WRITE: state <= debug_pkg::HDR;
              debug_pkg::CMD_ID:
              begin
                id_pending <= 1'b1;
                state      <= debug_pkg::DONE;
              end
              default: state <= debug_pkg::DONE;  // unknown command
            endcase
          end
          debug_pkg::HDR:
          begin
            hdr_idx <= hdr_idx + 1'b1;
            if (hdr_idx == debug_pkg::HDR_IDX_W'(0))
              addr_q[debug_pkg::ADDR_W-1:debug_pkg::DATA_W] <= i_rx_byte;
            else if (hdr_idx == debug_pkg::HDR_IDX_W'(1))
              addr_q[debug_pkg::DATA_W-1:0] <= i_rx_byte;
            else if (hdr_idx == debug_pkg::HDR_IDX_W'(2))
              count_q[debug_pkg::ADDR_W-1:debug_pkg::DATA_W] <= i_rx_byte;
            else if (hdr_idx == debug_pkg::HDR_IDX_W'(debug_pkg::HDR_BYTES - 1))
            begin
              count_q <= hdr_len;
              if (hdr_len == '0)
                state <= debug_pkg::DONE;
              else if (cmd_q == debug_pkg::CMD_READ)
              begin
                o_mem_en <= 1'b1;                // prefetch for dummy byte 0
                count_q  <= hdr_len - 1'b1;
                state    <= debug_pkg::RD_DATA;
              end
              else
                state <= debug_pkg::WR_DATA;
            end
          end
          debug_pkg::RD_DATA:
          begin
            if (count_q == '0)
              state <= debug_pkg::DONE;          // last reply already loaded
            else
            begin
              o_mem_en <= 1'b1;
              count_q  <= count_q - 1'b1;
            end
          end
          debug_pkg::WR_DATA:
          begin
            o_mem_en <= 1'b1;
            o_mem_we <= 1'b1;
            count_q  <= count_q - 1'b1;
            if (count_q == debug_pkg::addr_t'(1))
              state <= debug_pkg::DONE;
          end
          debug_pkg::DONE: state <= debug_pkg::DONE;
          default: state <= debug_pkg::CMD;
        endcase
      end
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (i_rx_dv)
      o_mem_wdata <= i_rx_byte;
  end

  assign o_mem_addr = addr_q;
  assign o_tx_dv    = id_pending | rd_pending;
  assign o_tx_byte  = id_pending ? debug_pkg::ID_VALUE : i_mem_rdata;

  // accesses are cut off when the SPI frame ends
  a_mem_in_frame: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_mem_en |-> i_frame_active);

  // one access per received byte
  a_single_access: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_mem_en |=> !o_mem_en);

endmodule

// File: design/debug_memory.sv
/* 64 KiB single-port byte RAM, read data registered one cycle after an enabled read.
   No reset, contents are undefined until written. */
`timescale 1ns/1ns

module debug_memory (
  input  logic             i_clk,
  input  logic             i_en,
  input  logic             i_we,
  input  debug_pkg::addr_t i_addr,
  input  debug_pkg::byte_t i_wdata,
  output debug_pkg::byte_t o_rdata
);

  debug_pkg::byte_t mem [2**debug_pkg::ADDR_W];

  always_ff @(posedge i_clk)
  begin
    if (i_en)
    begin
      if (i_we)
        mem[i_addr] <= i_wdata;
      else
        o_rdata <= mem[i_addr];                  // holds during writes
    end
  end

endmodule

// File: design/debugger_top.sv
/* SPI memory debugger top. CIPO is driven at all times and is 0 outside a frame.
   SCK high and low times must each be at least 4 i_clk cycles. */
`timescale 1ns/1ns

module debugger_top (
  input  logic i_clk,
  input  logic i_arst_n,
  input  logic i_spi_clk,
  input  logic i_spi_cs_n,
  input  logic i_spi_copi,
  output logic o_spi_cipo
);

  debug_pkg::byte_t rx_byte;
  logic             rx_dv;
  logic             frame_active;
  debug_pkg::byte_t tx_byte;
  logic             tx_dv;

  logic             mem_en;
  logic             mem_we;
  debug_pkg::addr_t mem_addr;
  debug_pkg::byte_t mem_wdata;
  debug_pkg::byte_t mem_rdata;

  spi_peripheral spi (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_spi_clk      (i_spi_clk),
    .i_spi_cs_n     (i_spi_cs_n),
    .i_spi_copi     (i_spi_copi),
    .i_tx_dv        (tx_dv),
    .i_tx_byte      (tx_byte),
    .o_spi_cipo     (o_spi_cipo),
    .o_rx_byte      (rx_byte),
    .o_rx_dv        (rx_dv),
    .o_frame_active (frame_active)               // controller idles when low
  );

  debug_controller ctrl (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_rx_dv        (rx_dv),
    .i_rx_byte      (rx_byte),
    .i_frame_active (frame_active),
    .i_mem_rdata    (mem_rdata),
    .o_tx_dv        (tx_dv),
    .o_tx_byte      (tx_byte),
    .o_mem_en       (mem_en),
    .o_mem_we       (mem_we),
    .o_mem_addr     (mem_addr),
    .o_mem_wdata    (mem_wdata)
  );

  debug_memory memory (
    .i_clk   (i_clk),
    .i_en    (mem_en),
    .i_we    (mem_we),
    .i_addr  (mem_addr),
    .i_wdata (mem_wdata),
    .o_rdata (mem_rdata)
  );

endmodule

// File: filelist.f
common/debug_pkg.sv
spi/spi_peripheral.sv
debugger/debug_controller.sv
design/debug_memory.sv
design/debugger_top.sv
bench/clock_gen.sv
bench/debugger_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the debugger testbench with Verilator, runs it and checks for the pass message.
cd "$(dirname "$0")" || exit 1

sim_out=$(verilator --binary --timing --assert -j 0 --top-module debugger_tb \
  --Mdir obj_dir -f filelist.f 2>&1 && ./obj_dir/Vdebugger_tb 2>&1)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qF 'All tests passed!' && echo "Simulation PASSED" && exit 0 \
  || { echo "Simulation FAILED"; exit 1; }

// File: spi/spi_peripheral.sv
/* SPI mode 0 peripheral, MSB first, oversampled in the i_clk domain.
   SCK high and low times must each be at least 4 i_clk cycles.
   A byte not loaded before the next byte starts goes out as 0x00. */
`timescale 1ns/1ns

module spi_peripheral (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  logic             i_spi_clk,
  input  logic             i_spi_cs_n,
  input  logic             i_spi_copi,
  input  logic             i_tx_dv,
  input  debug_pkg::byte_t i_tx_byte,
  output logic             o_spi_cipo,
  output debug_pkg::byte_t o_rx_byte,
  output logic             o_rx_dv,
  output logic             o_frame_active
);

  logic [2:0] sck_sync;                           // 2 sync stages + edge detect
  logic [2:0] cs_sync;
  logic [1:0] copi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic       frame_start;

  logic [debug_pkg::BIT_CNT_W-1:0] rx_cnt;
  logic [debug_pkg::BIT_CNT_W-1:0] tx_cnt;
  logic [debug_pkg::DATA_W-2:0]    rx_shift;      // first 7 bits of the byte
  debug_pkg::byte_t                tx_shift;
  debug_pkg::byte_t                tx_buf;        // next byte to send

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      sck_sync  <= '0;
      cs_sync   <= '1;                            // chip select idles high
      copi_sync <= '0;
    end
    else
    begin
      sck_sync  <= {sck_sync[1:0], i_spi_clk};
      cs_sync   <= {cs_sync[1:0], i_spi_cs_n};
      copi_sync <= {copi_sync[0], i_spi_copi};
    end
  end

  assign sck_rise       = sck_sync[1] & ~sck_sync[2];
  assign sck_fall       = ~sck_sync[1] & sck_sync[2];
  assign o_frame_active = ~cs_sync[1];
  assign frame_start    = ~cs_sync[1] & cs_sync[2];

  // receive side samples COPI on SCK rise
  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      rx_cnt  <= '0;
      o_rx_dv <= 1'b0;
    end
    else
    begin
      o_rx_dv <= 1'b0;
      if (!o_frame_active)
        rx_cnt <= '0;                             // drop partial byte
      else if (sck_rise)
      begin
        rx_cnt  <= rx_cnt + 1'b1;
        o_rx_dv <= (rx_cnt == debug_pkg::BIT_CNT_W'(debug_pkg::DATA_W - 1));
      end
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (sck_rise)
    begin
      rx_shift <= {rx_shift[debug_pkg::DATA_W-3:0], copi_sync[1]};
      if (rx_cnt == debug_pkg::BIT_CNT_W'(debug_pkg::DATA_W - 1))
        o_rx_byte <= {rx_shift, copi_sync[1]};
    end
  end

  // transmit side changes CIPO on SCK fall
  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      tx_buf   <= '0;
      tx_shift <= '0;
      tx_cnt   <= '0;
    end
    else if (!o_frame_active)
    begin
      tx_buf   <= '0;
      tx_shift <= '0;                             // keeps CIPO low between frames
      tx_cnt   <= '0;
    end
    else
    begin
      if (frame_start || (sck_fall && tx_cnt == debug_pkg::BIT_CNT_W'(debug_pkg::DATA_W - 1)))
      begin
        tx_shift <= tx_buf;                       // first bit of the next byte
        tx_buf   <= '0;                           // filler unless reloaded
        tx_cnt   <= '0;
      end
      else if (sck_fall)
      begin
        tx_shift <= {tx_shift[debug_pkg::DATA_W-2:0], 1'b0};
        tx_cnt   <= tx_cnt + 1'b1;
      end
      if (i_tx_dv)
        tx_buf <= i_tx_byte;                      // a load wins over the clear
    end
  end

  assign o_spi_cipo = tx_shift[debug_pkg::DATA_W-1];

  // SCK phases of at least 4 cycles keep synced edges 3 or more cycles apart
  a_sck_phase: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (sck_rise || sck_fall) |->
      !$past(sck_rise || sck_fall) && !$past(sck_rise || sck_fall, 2));

  // the controller answers only inside a frame
  a_tx_dv_in_frame: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_tx_dv |-> o_frame_active);

endmodule
